// ==== flist.f ====
+incdir+include
src/sched_stream_pkg.sv
src/sched_ctrl_pkg.sv
src/slot_pool.sv
src/core_picker.sv
src/desc_grant_arb.sv
src/lane_tagger.sv
src/host_regs.sv
src/pkt_scheduler.sv
tests/tb_pkt_scheduler.sv

// ==== tests/tb_pkt_scheduler.sv ====
// ====================
// Table-driven testbench with a model of the slot pools and lanes
// Packets run on lane 0 only, lane 1 stays idle after its first grant
// ====================
`timescale 1ns/1ns
`include "sched_params.svh"

module tb_pkt_scheduler;

  import sched_stream_pkg::*;
  import sched_ctrl_pkg::*;

  localparam int LANES       = `SCHED_LANE_COUNT;
  localparam int CORES       = `SCHED_CORE_COUNT;
  localparam int MAX_STEPS   = 64;
  localparam int MODEL_DEPTH = 16;

  typedef enum logic [2:0] {
    HOST_WR, HOST_RD, SLOT_MSG, SEND_PKTS, LANE_CHECK, POOL_CHECK
  } step_kind_t;

  // Host steps: a = {index, register code}; slot messages: a = {kind, core}
  // Packet steps: a = lane, b = packet count, exp = back-pressure on
  typedef struct packed {
    logic [3:0]  group;
    step_kind_t  kind;
    logic [15:0] a;
    logic [31:0] b;
    logic [31:0] exp;
  } step_t;

  logic       clk;
  logic       rst_r;
  lane_beat_t rx_beat [LANES];
  lane_mask_t rx_valid;
  lane_mask_t rx_ready;
  lane_beat_t tx_beat [LANES];
  dest_tag_t  tx_dest [LANES];
  lane_mask_t tx_valid;
  lane_mask_t tx_ready;
  slot_msg_t  slot_msg;
  logic       slot_msg_valid;
  host_cmd_t  host_cmd;
  host_word_t host_cmd_wr_data;
  logic       host_cmd_valid;
  host_word_t host_cmd_rd_data;

  step_t       steps [MAX_STEPS];
  int          n_steps;
  logic        table_ready = 1'b0;
  int          cycles;
  int          cycle_limit;
  int          errors;
  int          step_errors;
  int          steps_failed;
  int          pkt_id;
  logic [31:0] lfsr_state;

  // Reference model state
  int         pool_mem [CORES][MODEL_DEPTH];
  int         pool_head [CORES];
  int         pool_cnt [CORES];
  dest_tag_t  lane_held [LANES];
  logic       lane_open [LANES];
  core_mask_t m_enabled;
  core_mask_t m_income;
  int         rr_ptr;

  pkt_scheduler pkt_scheduler_inst (
    .clk              (clk),
    .rst_r            (rst_r),
    .rx_beat          (rx_beat),
    .rx_valid         (rx_valid),
    .rx_ready         (rx_ready),
    .tx_beat          (tx_beat),
    .tx_dest          (tx_dest),
    .tx_valid         (tx_valid),
    .tx_ready         (tx_ready),
    .slot_msg         (slot_msg),
    .slot_msg_valid   (slot_msg_valid),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_lfsr_bit());
    end
    return v;
  endfunction

  function automatic logic [15:0] reg_at(input int code, input int idx);
    return 16'((idx << 8) | code);
  endfunction

  function automatic logic [15:0] msg_of(input slot_msg_kind_t kind, input int core);
    return 16'((int'(kind) << 8) | core);
  endfunction

  function automatic int step_cycles(input step_t s);
    case (s.kind)
      SEND_PKTS:  return int'(s.b) * 16;
      POOL_CHECK: return CORES * 5;
      default:    return 6;
    endcase
  endfunction

  task automatic add_step(input int group, input step_kind_t kind, input logic [15:0] a,
                          input logic [31:0] b, input logic [31:0] exp);
    steps[n_steps] = {4'(group), kind, a, b, exp};
    n_steps++;
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("MISMATCH time %0t %s got %0h expected %0h", $time, name, got, exp);
    step_errors++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Largest free count among accepting cores, lowest index wins, -1 if none
  function automatic int model_pick();
    int best_core;
    int best_cnt;
    best_core = -1;
    best_cnt  = 0;
    for (int c = 0; c < CORES; c++) begin
      if (m_income[c] && m_enabled[c] && (pool_cnt[c] > best_cnt)) begin
        best_cnt  = pool_cnt[c];
        best_core = c;
      end
    end
    return best_core;
  endfunction

  task automatic model_take(input int lane, output logic ok);
    int c;
    c  = model_pick();
    ok = (c >= 0);
    if (ok) begin
      lane_held[lane].core = core_id_t'(c);
      lane_held[lane].slot = slot_t'(pool_mem[c][pool_head[c]]);
      pool_head[c] = (pool_head[c] + 1) % MODEL_DEPTH;
      pool_cnt[c]--;
      lane_open[lane] = 1'b1;
      rr_ptr = (lane + 1) % LANES;
    end
  endtask

  // Closed lanes take descriptors in round-robin order while any pool offers one
  task automatic model_fill_stalled();
    int   lane;
    int   found;
    logic ok;
    ok = 1'b1;
    while (ok) begin
      found = -1;
      for (int k = LANES - 1; k >= 0; k--) begin
        lane = (rr_ptr + k) % LANES;
        if (!lane_open[lane]) begin
          found = lane;
        end
      end
      ok = 1'b0;
      if (found >= 0) begin
        model_take(found, ok);
      end
    end
  endtask

  task automatic model_write(input logic [4:0] code, input logic [31:0] data);
    case (code)
      CORE_ENABLE: begin
        m_enabled = data[CORES-1:0];
        m_income  = m_income & data[CORES-1:0];
      end
      CORE_INCOME: m_income = data[CORES-1:0] & m_enabled;
      CORE_FLUSH: begin
        for (int c = 0; c < CORES; c++) begin
          if (data[c]) begin
            pool_cnt[c]  = 0;
            pool_head[c] = 0;
          end
        end
      end
      LANE_RELEASE: begin
        for (int l = 0; l < LANES; l++) begin
          if (data[l]) begin
            lane_open[l] = 1'b0;
          end
        end
      end
      default: ;
    endcase
    model_fill_stalled();
  endtask

  task automatic model_slot_msg(input logic is_init, input int core, input int value);
    if (is_init) begin
      pool_head[core] = 0;
      pool_cnt[core]  = value;
      for (int i = 0; i < value; i++) begin
        pool_mem[core][i] = i + 1;
      end
    end else begin
      pool_mem[core][(pool_head[core] + pool_cnt[core]) % MODEL_DEPTH] = value;
      pool_cnt[core]++;
    end
    model_fill_stalled();
  endtask

  task automatic host_write(input logic [15:0] a, input logic [31:0] data);
    host_cmd             = '0;
    host_cmd.wr          = 1'b1;
    host_cmd.sched_wr    = 1'b1;
    host_cmd.if_not_core = a[4];
    host_cmd.addr        = a[3:0];
    host_cmd.index       = a[11:8];
    host_cmd_wr_data     = data;
    host_cmd_valid       = 1'b1;
    next_cycle();
    host_cmd_valid = 1'b0;
    // Write lands at the second edge, grants may follow on the next two
    repeat (4) next_cycle();
  endtask

  task automatic host_read(input logic [15:0] a, output logic [31:0] data);
    host_cmd             = '0;
    host_cmd.if_not_core = a[4];
    host_cmd.addr        = a[3:0];
    host_cmd.index       = a[11:8];
    repeat (3) next_cycle();
    #4;
    data = host_cmd_rd_data;
    next_cycle();
  endtask

  task automatic send_slot_msg(input logic [15:0] a, input logic [31:0] b);
    slot_msg.kind  = slot_msg_kind_t'(a[8]);
    slot_msg.core  = core_id_t'(a[1:0]);
    slot_msg.slot  = slot_t'(b);
    slot_msg_valid = 1'b1;
    next_cycle();
    slot_msg_valid = 1'b0;
    repeat (3) next_cycle();
  endtask

  task automatic send_packets(input int lane, input int count, input logic stall);
    int         len;
    logic       moved;
    logic       ok;
    dest_tag_t  exp_dest;
    lane_beat_t beat;
    for (int p = 0; p < count; p++) begin
      len      = take_bits(2) + 1;
      exp_dest = lane_held[lane];
      for (int i = 0; i < len; i++) begin
        beat.data      = {pkt_id, 32'(i)};
        beat.last      = (i == len - 1);
        rx_beat[lane]  = beat;
        rx_valid[lane] = 1'b1;
        moved          = 1'b0;
        while (!moved) begin
          tx_ready[lane] = stall ? (take_bits(2) != 3) : 1'b1;
          #4;
          if (tx_valid[lane] !== 1'b1) begin
            report_mismatch("tx_valid", tx_valid[lane], 1'b1);
          end
          if (tx_beat[lane] !== beat) begin
            report_mismatch("tx_beat", tx_beat[lane], beat);
          end
          if (rx_ready[lane] !== tx_ready[lane]) begin
            report_mismatch("rx_ready", rx_ready[lane], tx_ready[lane]);
          end
          if (rx_ready[lane] === 1'b1) begin
            moved = 1'b1;
            if (tx_dest[lane] !== exp_dest) begin
              report_mismatch("tx_dest", tx_dest[lane], exp_dest);
            end
            // First beat frees the held descriptor for a new one
            if (i == 0) begin
              model_take(lane, ok);
              if (!ok) begin
                $display("No accepting pool left to refill lane %0d", lane);
                step_errors++;
              end
            end
          end
          next_cycle();
        end
      end
      rx_valid[lane] = 1'b0;
      tx_ready[lane] = 1'b1;
      pkt_id++;
    end
  endtask

  task automatic run_step(input step_t s);
    int          lane;
    logic [31:0] rd;
    logic [31:0] exp_word;
    case (s.kind)
      HOST_WR: begin
        host_write(s.a, s.b);
        model_write(s.a[4:0], s.b);
      end
      HOST_RD: begin
        host_read(s.a, rd);
        if (rd !== s.exp) begin
          report_mismatch("host_cmd_rd_data", rd, s.exp);
        end
      end
      SLOT_MSG: begin
        send_slot_msg(s.a, s.b);
        model_slot_msg(s.a[8], int'(s.a[1:0]), int'(s.b));
      end
      SEND_PKTS: send_packets(int'(s.a), int'(s.b), s.exp[0]);
      LANE_CHECK: begin
        lane = int'(s.a);
        host_read(reg_at(LANE_STATE, lane), rd);
        // An idle open lane rests in FIRST
        exp_word = {14'd0, (lane_open[lane] ? FIRST : STALL),
                    8'(lane_held[lane].core), 8'(lane_held[lane].slot)};
        if (rd !== exp_word) begin
          report_mismatch("lane_state", rd, exp_word);
        end
        #4;
        if (rx_ready[lane] !== lane_open[lane]) begin
          report_mismatch("rx_ready", rx_ready[lane], lane_open[lane]);
        end
        // Waiting for a packet, the lane shows its held descriptor
        if (lane_open[lane] && (tx_dest[lane] !== lane_held[lane])) begin
          report_mismatch("tx_dest", tx_dest[lane], lane_held[lane]);
        end
        next_cycle();
      end
      POOL_CHECK: begin
        for (int c = 0; c < CORES; c++) begin
          host_read(reg_at(CORE_SLOTS, c), rd);
          if (rd !== 32'(pool_cnt[c])) begin
            report_mismatch("core_slots", rd, 32'(pool_cnt[c]));
          end
        end
      end
      default: ;
    endcase
  endtask

  task automatic load_steps();
    n_steps = 0;
    add_step(1, HOST_RD, reg_at(CORE_ENABLE, 0), 0, 32'h0);
    add_step(1, HOST_RD, reg_at(CORE_INCOME, 0), 0, 32'h0);
    add_step(1, HOST_RD, reg_at(LANE_STATE, 0), 0, 32'h0);
    add_step(1, HOST_RD, reg_at(LANE_STATE, 1), 0, 32'h0);
    add_step(1, HOST_RD, reg_at(5'h05, 0), 0, 32'hFEFE_FEFE);
    add_step(1, LANE_CHECK, 0, 0, 0);
    add_step(1, LANE_CHECK, 1, 0, 0);
    add_step(2, HOST_WR, reg_at(CORE_ENABLE, 0), 32'b0101, 0);
    add_step(2, HOST_WR, reg_at(CORE_INCOME, 0), 32'b1111, 0);
    add_step(2, HOST_RD, reg_at(CORE_INCOME, 0), 0, 32'b0101);
    add_step(2, HOST_WR, reg_at(CORE_ENABLE, 0), 32'b0001, 0);
    add_step(2, HOST_RD, reg_at(CORE_INCOME, 0), 0, 32'b0001);
    // Close all cores so the INIT messages cause no grants yet
    add_step(3, HOST_WR, reg_at(CORE_ENABLE, 0), 32'h0, 0);
    add_step(3, SLOT_MSG, msg_of(INIT, 0), 3, 0);
    add_step(3, SLOT_MSG, msg_of(INIT, 1), 5, 0);
    add_step(3, SLOT_MSG, msg_of(INIT, 2), 5, 0);
    add_step(3, SLOT_MSG, msg_of(INIT, 3), 2, 0);
    add_step(3, HOST_WR, reg_at(CORE_ENABLE, 0), 32'hF, 0);
    add_step(3, HOST_WR, reg_at(CORE_INCOME, 0), 32'hF, 0);
    add_step(3, HOST_RD, reg_at(LANE_STATE, 0), 0, 32'h0001_0101);
    add_step(3, HOST_RD, reg_at(LANE_STATE, 1), 0, 32'h0001_0201);
    add_step(3, HOST_RD, reg_at(CORE_SLOTS, 0), 0, 32'd3);
    add_step(3, HOST_RD, reg_at(CORE_SLOTS, 1), 0, 32'd4);
    add_step(3, HOST_RD, reg_at(CORE_SLOTS, 2), 0, 32'd4);
    add_step(3, HOST_RD, reg_at(CORE_SLOTS, 3), 0, 32'd2);
    add_step(4, SEND_PKTS, 0, 5, 1);
    add_step(4, LANE_CHECK, 0, 0, 0);
    add_step(4, LANE_CHECK, 1, 0, 0);
    add_step(4, POOL_CHECK, 0, 0, 0);
    add_step(5, SLOT_MSG, msg_of(RETURN, 3), 6, 0);
    add_step(5, SLOT_MSG, msg_of(RETURN, 3), 8, 0);
    add_step(5, SLOT_MSG, msg_of(RETURN, 3), 7, 0);
    add_step(5, POOL_CHECK, 0, 0, 0);
    add_step(5, SEND_PKTS, 0, 8, 0);
    add_step(5, POOL_CHECK, 0, 0, 0);
    add_step(5, HOST_WR, reg_at(CORE_FLUSH, 0), 32'b1000, 0);
    add_step(5, HOST_RD, reg_at(CORE_SLOTS, 3), 0, 32'd0);
    add_step(5, SEND_PKTS, 0, 2, 0);
    add_step(5, POOL_CHECK, 0, 0, 0);
    add_step(6, HOST_WR, reg_at(CORE_INCOME, 0), 32'h0, 0);
    add_step(6, SLOT_MSG, msg_of(RETURN, 1), 4, 0);
    add_step(6, HOST_WR, reg_at(LANE_RELEASE, 0), 32'b11, 0);
    add_step(6, LANE_CHECK, 0, 0, 0);
    add_step(6, LANE_CHECK, 1, 0, 0);
    add_step(6, POOL_CHECK, 0, 0, 0);
  endtask

  initial begin
    cycles = 0;
    wait (table_ready);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_r            = 1'b1;
    rx_valid         = '0;
    tx_ready         = '1;
    slot_msg         = '0;
    slot_msg_valid   = 1'b0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      rx_beat[l]   = '0;
      lane_held[l] = '0;
      lane_open[l] = 1'b0;
    end
    for (int c = 0; c < CORES; c++) begin
      pool_head[c] = 0;
      pool_cnt[c]  = 0;
    end
    m_enabled    = '0;
    m_income     = '0;
    rr_ptr       = 0;
    errors       = 0;
    steps_failed = 0;
    pkt_id       = 0;
    lfsr_state   = 32'hf69f;
    load_steps();
    cycle_limit = 0;
    for (int s = 0; s < n_steps; s++) begin
      cycle_limit += step_cycles(steps[s]);
    end
    cycle_limit = cycle_limit * 4 + 200;
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_r = 1'b0;
    next_cycle();
    for (int s = 0; s < n_steps; s++) begin
      step_errors = 0;
      run_step(steps[s]);
      if (step_errors == 0) begin
        $display("Behavior %0d step %0d %s ok", steps[s].group, s, steps[s].kind.name());
      end else begin
        $display("Behavior %0d step %0d %s had %0d errors", steps[s].group, s,
                 steps[s].kind.name(), step_errors);
        steps_failed++;
      end
      errors += step_errors;
    end
    $display("Steps run %0d, steps failed %0d, errors %0d", n_steps, steps_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src/pkt_scheduler.sv ====
// ====================
// Receive scheduler top; lanes pass through unregistered
// Slot messages are always accepted and act at the next edge
// ====================
`timescale 1ns/1ns
`include "sched_params.svh"

module pkt_scheduler (
  input  logic                         clk,
  input  logic                         rst_r,
  input  sched_stream_pkg::lane_beat_t rx_beat [`SCHED_LANE_COUNT],
  input  sched_stream_pkg::lane_mask_t rx_valid,
  output sched_stream_pkg::lane_mask_t rx_ready,
  output sched_stream_pkg::lane_beat_t tx_beat [`SCHED_LANE_COUNT],
  output sched_stream_pkg::dest_tag_t  tx_dest [`SCHED_LANE_COUNT],
  output sched_stream_pkg::lane_mask_t tx_valid,
  input  sched_stream_pkg::lane_mask_t tx_ready,
  input  sched_stream_pkg::slot_msg_t  slot_msg,
  input  logic                         slot_msg_valid,
  input  sched_ctrl_pkg::host_cmd_t    host_cmd,
  input  sched_ctrl_pkg::host_word_t   host_cmd_wr_data,
  input  logic                         host_cmd_valid,
  output sched_ctrl_pkg::host_word_t   host_cmd_rd_data
);

  import sched_stream_pkg::*;
  import sched_ctrl_pkg::*;

  localparam int LANE_COUNT = `SCHED_LANE_COUNT;
  localparam int CORE_COUNT = `SCHED_CORE_COUNT;

  core_mask_t  enabled;
  core_mask_t  income;
  core_mask_t  accept;
  core_mask_t  flush;
  lane_mask_t  release_desc;
  lane_mask_t  desc_req;
  lane_mask_t  grant;
  logic        grant_valid;
  logic        pick_valid;
  core_id_t    pick;
  dest_tag_t   new_desc;
  slot_t       counts [CORE_COUNT];
  slot_t       heads [CORE_COUNT];
  lane_state_t lane_states [LANE_COUNT];
  dest_tag_t   lane_descs [LANE_COUNT];

  host_regs host_regs_inst (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data),
    .enabled          (enabled),
    .income           (income),
    .flush            (flush),
    .release_desc     (release_desc),
    .counts           (counts),
    .lane_states      (lane_states),
    .lane_descs       (lane_descs)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_pool
    logic msg_hit;

    assign msg_hit = slot_msg_valid && (slot_msg.core == core_id_t'(c));

    slot_pool slot_pool_inst (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (flush[c]),
      .init_valid (msg_hit && (slot_msg.kind == INIT)),
      .ret_valid  (msg_hit && (slot_msg.kind == RETURN)),
      .slot_in    (slot_msg.slot),
      .pop        (grant_valid && (pick == core_id_t'(c))),
      .head       (heads[c]),
      .count      (counts[c])
    );
  end

  assign accept = income & enabled;

  core_picker core_picker_inst (
    .counts     (counts),
    .income     (accept),
    .pick       (pick),
    .pick_valid (pick_valid)
  );

  desc_grant_arb desc_grant_arb_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .req         (desc_req),
    .avail       (pick_valid),
    .grant       (grant),
    .grant_valid (grant_valid)
  );

  // Head of the picked pool goes to the granted lane
  assign new_desc.core = pick;
  assign new_desc.slot = heads[pick];

  for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
    lane_tagger lane_tagger_inst (
      .clk          (clk),
      .rst_r        (rst_r),
      .rx_beat      (rx_beat[l]),
      .rx_valid     (rx_valid[l]),
      .rx_ready     (rx_ready[l]),
      .tx_beat      (tx_beat[l]),
      .tx_valid     (tx_valid[l]),
      .tx_ready     (tx_ready[l]),
      .tx_dest      (tx_dest[l]),
      .granted      (grant[l]),
      .new_desc     (new_desc),
      .release_desc (release_desc[l]),
      .desc_req     (desc_req[l]),
      .state        (lane_states[l]),
      .held_desc    (lane_descs[l])
    );
  end

endmodule

// ==== src/host_regs.sv ====
// ====================
// Host command decode; writes land two edges after the command
// Read data is valid three edges after it while the command holds
// ====================
`timescale 1ns/1ns
`include "sched_params.svh"

module host_regs (
  input  logic                         clk,
  input  logic                         rst_r,
  input  sched_ctrl_pkg::host_cmd_t    host_cmd,
  input  sched_ctrl_pkg::host_word_t   host_cmd_wr_data,
  input  logic                         host_cmd_valid,
  output sched_ctrl_pkg::host_word_t   host_cmd_rd_data,
  output sched_stream_pkg::core_mask_t enabled,
  output sched_stream_pkg::core_mask_t income,
  output sched_stream_pkg::core_mask_t flush,
  output sched_stream_pkg::lane_mask_t release_desc,
  input  sched_stream_pkg::slot_t      counts [`SCHED_CORE_COUNT],
  input  sched_ctrl_pkg::lane_state_t  lane_states [`SCHED_LANE_COUNT],
  input  sched_stream_pkg::dest_tag_t  lane_descs [`SCHED_LANE_COUNT]
);

  import sched_stream_pkg::*;
  import sched_ctrl_pkg::*;

  localparam int LANE_IDX_W = $clog2(`SCHED_LANE_COUNT);

  host_cmd_t             cmd_r;
  host_word_t            wr_data_r;
  logic                  wr_r;
  host_reg_t             reg_sel;
  core_id_t              core_sel;
  logic [LANE_IDX_W-1:0] lane_sel;
  host_word_t            rd_next;
  host_word_t            rd_r;

  always_ff @(posedge clk) begin
    cmd_r     <= host_cmd;
    wr_data_r <= host_cmd_wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r <= 1'b0;
    end else begin
      wr_r <= host_cmd_valid && host_cmd.wr && host_cmd.sched_wr;
    end
  end

  assign reg_sel  = host_reg_t'({cmd_r.if_not_core, cmd_r.addr});
  assign core_sel = cmd_r.index[$bits(core_id_t)-1:0];
  assign lane_sel = cmd_r.index[LANE_IDX_W-1:0];

  // Flush and release are single-cycle strobes
  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled      <= '0;
      income       <= '0;
      flush        <= '0;
      release_desc <= '0;
    end else begin
      flush        <= '0;
      release_desc <= '0;
      if (wr_r) begin
        case (reg_sel)
          CORE_ENABLE: begin
            // A disabled core cannot keep accepting traffic
            enabled <= wr_data_r[`SCHED_CORE_COUNT-1:0];
            income  <= income & wr_data_r[`SCHED_CORE_COUNT-1:0];
          end
          CORE_INCOME:  income       <= wr_data_r[`SCHED_CORE_COUNT-1:0] & enabled;
          CORE_FLUSH:   flush        <= wr_data_r[`SCHED_CORE_COUNT-1:0];
          LANE_RELEASE: release_desc <= wr_data_r[`SCHED_LANE_COUNT-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (reg_sel)
      CORE_ENABLE: rd_next = host_word_t'(enabled);
      CORE_INCOME: rd_next = host_word_t'(income);
      CORE_SLOTS:  rd_next = host_word_t'(counts[core_sel]);
      LANE_STATE:  rd_next = {14'd0, lane_states[lane_sel],
                              8'(lane_descs[lane_sel].core),
                              8'(lane_descs[lane_sel].slot)};
      default:     rd_next = `SCHED_RD_DEFAULT;
    endcase
  end

  always_ff @(posedge clk) begin
    rd_r             <= rd_next;
    host_cmd_rd_data <= rd_r;
  end

endmodule

// ==== src/lane_tagger.sv ====
// ====================
// Per-lane descriptor FSM; data passes through combinationally
// A lane is closed in STALL until it is granted a descriptor
// ====================
`timescale 1ns/1ns

module lane_tagger (
  input  logic                          clk,
  input  logic                          rst_r,
  input  sched_stream_pkg::lane_beat_t  rx_beat,
  input  logic                          rx_valid,
  output logic                          rx_ready,
  output sched_stream_pkg::lane_beat_t  tx_beat,
  output logic                          tx_valid,
  input  logic                          tx_ready,
  output sched_stream_pkg::dest_tag_t   tx_dest,
  input  logic                          granted,
  input  sched_stream_pkg::dest_tag_t   new_desc,
  input  logic                          release_desc,
  output logic                          desc_req,
  output sched_ctrl_pkg::lane_state_t   state,
  output sched_stream_pkg::dest_tag_t   held_desc
);

  import sched_stream_pkg::*;
  import sched_ctrl_pkg::*;

  logic      active;
  logic      moving;
  logic      last_moving;
  dest_tag_t pkt_desc;

  assign active      = (state != STALL);
  assign tx_beat     = rx_beat;
  assign tx_valid    = rx_valid && active;
  assign rx_ready    = tx_ready && active;
  assign moving      = rx_valid && rx_ready;
  assign last_moving = moving && rx_beat.last;

  // A packet start uses up the held descriptor, so ask for the next one
  assign desc_req = (state == STALL) || (state == WAIT) || ((state == FIRST) && moving);
  assign tx_dest  = (state == FIRST) ? held_desc : pkt_desc;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= STALL;
    end else begin
      case (state)
        STALL: begin
          if (granted) begin
            state <= FIRST;
          end
        end
        FIRST: begin
          // Grant on the first beat already refilled the held descriptor
          if (last_moving) begin
            state <= granted ? FIRST : STALL;
          end else if (moving) begin
            state <= granted ? MID : WAIT;
          end else if (release_desc) begin
            state <= STALL;
          end
        end
        WAIT: begin
          if (granted) begin
            state <= last_moving ? FIRST : MID;
          end else if (last_moving) begin
            state <= STALL;
          end
        end
        MID: begin
          if (last_moving) begin
            state <= release_desc ? STALL : FIRST;
          end else if (release_desc) begin
            // Drop the reserved one, request again
            state <= WAIT;
          end
        end
        default: state <= STALL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      held_desc <= '0;
    end else if (granted) begin
      held_desc <= new_desc;
    end
  end

  // Descriptor of the packet in flight, taken at its first beat
  always_ff @(posedge clk) begin
    if ((state == FIRST) && moving) begin
      pkt_desc <= held_desc;
    end
  end

  // Arbiter only grants a lane that asked for a descriptor
  assert property (@(posedge clk) disable iff (rst_r)
    granted |-> desc_req)
    else $error("lane_tagger: grant without a request");

endmodule

// ==== src/desc_grant_arb.sv ====
// ====================
// Round-robin descriptor grant, one lane per cycle
// ====================
`timescale 1ns/1ns
`include "sched_params.svh"

module desc_grant_arb (
  input  logic                         clk,
  input  logic                         rst_r,
  input  sched_stream_pkg::lane_mask_t req,
  input  logic                         avail,
  output sched_stream_pkg::lane_mask_t grant,
  output logic                         grant_valid
);

  import sched_stream_pkg::*;

  localparam int LANE_COUNT = `SCHED_LANE_COUNT;
  localparam int IDX_W      = $clog2(LANE_COUNT);

  typedef logic [IDX_W-1:0] lane_idx_t;

  // First lane to look at in the next search
  lane_idx_t ptr;
  lane_idx_t idx;
  lane_idx_t win;
  logic      found;

  always_comb begin
    grant = '0;
    found = 1'b0;
    win   = ptr;
    idx   = ptr;
    for (int k = 0; k < LANE_COUNT; k++) begin
      idx = lane_idx_t'((int'(ptr) + k) % LANE_COUNT);
      if (!found && req[idx]) begin
        found = 1'b1;
        win   = idx;
      end
    end
    if (avail && found) begin
      grant[win] = 1'b1;
    end
  end

  assign grant_valid = avail && found;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      ptr <= '0;
    end else if (grant_valid) begin
      ptr <= (int'(win) == LANE_COUNT - 1) ? '0 : win + 1'b1;
    end
  end

endmodule

// ==== src/core_picker.sv ====
// ====================
// Picks the accepting core with the most free slots
// Ties go to the lowest core index
// ====================
`timescale 1ns/1ns
`include "sched_params.svh"

module core_picker (
  input  sched_stream_pkg::slot_t      counts [`SCHED_CORE_COUNT],
  input  sched_stream_pkg::core_mask_t income,
  output sched_stream_pkg::core_id_t   pick,
  output logic                         pick_valid
);

  import sched_stream_pkg::*;

  localparam int CORE_COUNT = `SCHED_CORE_COUNT;

  slot_t best;

  // Strict compare keeps the earlier core on equal counts
  always_comb begin
    best = '0;
    pick = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (income[c] && (counts[c] > best)) begin
        best = counts[c];
        pick = core_id_t'(c);
      end
    end
  end

  // Empty pools never beat zero
  assign pick_valid = (best != '0);

endmodule

// ==== src/slot_pool.sv ====
// ====================
// Free slot FIFO of one core, at most SCHED_SLOT_COUNT entries
// Flush and INIT discard every queued slot
// ====================
`timescale 1ns/1ns
`include "sched_params.svh"

module slot_pool (
  input  logic                    clk,
  input  logic                    rst_r,
  input  logic                    flush,
  input  logic                    init_valid,
  input  logic                    ret_valid,
  input  sched_stream_pkg::slot_t slot_in,
  input  logic                    pop,
  output sched_stream_pkg::slot_t head,
  output sched_stream_pkg::slot_t count
);

  import sched_stream_pkg::*;

  localparam int DEPTH = `SCHED_SLOT_COUNT;
  localparam int PTR_W = $clog2(DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  slot_t mem [DEPTH];
  ptr_t  rd_ptr;
  ptr_t  wr_ptr;
  slot_t count_r;

  // INIT writes 1..DEPTH, only the first N are counted
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (ret_valid) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_r <= '0;
    end else if (init_valid) begin
      rd_ptr  <= '0;
      wr_ptr  <= ptr_t'(slot_in);
      count_r <= slot_in;
    end else if (flush) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_r <= '0;
    end else begin
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (ret_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      case ({ret_valid, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign count = count_r;

  // Cores never hand back more slots than they were given
  assert property (@(posedge clk) disable iff (rst_r)
    ret_valid && !pop && !init_valid && !flush |-> count_r != slot_t'(DEPTH))
    else $error("slot_pool: RETURN into a full pool");

  // Picker must only offer a core that still has a slot
  assert property (@(posedge clk) disable iff (rst_r)
    pop |-> count_r != '0)
    else $error("slot_pool: pop from an empty pool");

endmodule

// ==== src/sched_ctrl_pkg.sv ====
// ====================
// Host command word, register codes and lane states
// ====================
package sched_ctrl_pkg;

  typedef logic [31:0] host_word_t;

  typedef struct packed {
    logic        wr;
    logic        if_not_core;  // lane register instead of core register
    logic        sched_wr;
    logic [20:0] rsvd;
    logic [3:0]  index;
    logic [3:0]  addr;
  } host_cmd_t;

  // Code is {if_not_core, addr}
  typedef enum logic [4:0] {
    CORE_ENABLE  = 5'h00,
    CORE_INCOME  = 5'h01,
    CORE_FLUSH   = 5'h02,
    CORE_SLOTS   = 5'h03,
    LANE_STATE   = 5'h10,
    LANE_RELEASE = 5'h12
  } host_reg_t;

  typedef enum logic [1:0] {
    STALL = 2'b00,  // no descriptor, lane closed
    FIRST = 2'b01,  // descriptor held, waiting for a packet start
    WAIT  = 2'b10,  // in a packet, no next descriptor yet
    MID   = 2'b11   // in a packet, next descriptor held
  } lane_state_t;

endpackage

// ==== src/sched_stream_pkg.sv ====
// ====================
// Lane, descriptor and slot message types
// ====================
`include "sched_params.svh"

package sched_stream_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0]   core_id_t;
  typedef logic [`SCHED_CORE_COUNT-1:0]           core_mask_t;
  typedef logic [`SCHED_LANE_COUNT-1:0]           lane_mask_t;
  // Slot number or slot count, one bit wider than a slot index
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;
  typedef logic [`SCHED_DATA_WIDTH-1:0]           lane_word_t;

  typedef struct packed {
    lane_word_t data;
    logic       last;
  } lane_beat_t;

  // Core and slot that a packet is written to
  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } dest_tag_t;

  typedef enum logic {
    RETURN = 1'b0,
    INIT   = 1'b1
  } slot_msg_kind_t;

  // For INIT the slot field is the count N
  typedef struct packed {
    slot_msg_kind_t kind;
    core_id_t       core;
    slot_t          slot;
  } slot_msg_t;

endpackage

// ==== include/sched_params.svh ====
// ====================
// Build-time sizes of the receive scheduler
// Slot count must be a power of two, slot numbers run from 1
// ====================
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// Receive lanes and cores
`define SCHED_LANE_COUNT 2
`define SCHED_CORE_COUNT 4

// Free slots in each core memory
`define SCHED_SLOT_COUNT 8

`define SCHED_DATA_WIDTH 64

// Host read value of an unmapped register
`define SCHED_RD_DEFAULT 32'hFEFEFEFE

`endif
